/* ualink_settings.svh */
/*
 * bridge-wide constants: stream widths, queue count and depth,
 * burst memory geometry and the command opcodes
 */
`ifndef UALINK_SETTINGS_SVH
`define UALINK_SETTINGS_SVH

// stream widths
`define UALINK_DATA_WIDTH        64
`define UALINK_USER_WIDTH        32

// receive side
`define UALINK_NUM_QUEUES        5
`define UALINK_QUEUE_DEPTH_BITS  4     // 16 entries per queue

// burst memory and commands
`define UALINK_MEM_ADDR_WIDTH    8
`define UALINK_BURST_BEATS       8     // payload beats after the header
`define UALINK_OP_WRITE          16'h0245
`define UALINK_OP_READ           16'h0145

`endif

/* hdl/ualink_pkg.sv */
/*
 * shared types: stream beat, queue index, memory request, command mode
 */
`include "ualink_settings.svh"

package ualink_pkg;

   // one AXI-Stream beat as it travels through the bridge
   typedef struct packed {
      logic [`UALINK_DATA_WIDTH-1:0]   data;
      logic [`UALINK_DATA_WIDTH/8-1:0] strb;
      logic [`UALINK_USER_WIDTH-1:0]   user;
      logic                            last;
   } axis_beat_t;

   typedef logic [$clog2(`UALINK_NUM_QUEUES)-1:0] queue_sel_t;

   // single port request into the burst memory
   typedef struct packed {
      logic                              en;
      logic                              we;
      logic [`UALINK_MEM_ADDR_WIDTH-1:0] addr;
      logic [`UALINK_DATA_WIDTH-1:0]     wdata;
   } mem_req_t;

   typedef enum logic [1:0] {CMD_PASS, CMD_WRITE, CMD_READ} cmd_mode_t;

endpackage

/* hdl/rx_queue.sv */
/*
 * fall-through receive FIFO, head entry always visible on dout
 * nearly_full one entry before full, payload type is a parameter
 */
module rx_queue #(
   parameter type T          = logic,
   parameter int  DEPTH_BITS = 4
) (
   input  logic axi_aclk,
   input  logic axi_resetn,
   input  T     din,
   input  logic wr_en,
   input  logic rd_en,
   output T     dout,
   output logic empty,
   output logic nearly_full
);

   localparam int DEPTH = 1 << DEPTH_BITS;

   T                      mem [DEPTH];
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;    // one extra bit to hold DEPTH
   logic                  do_wr;
   logic                  do_rd;

   assign do_wr = wr_en && !nearly_full;   // writes while nearly full are dropped
   assign do_rd = rd_en && !empty;

   always_ff @(posedge axi_aclk) begin
      if (do_wr) mem[wr_ptr] <= din;
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign dout        = mem[rd_ptr];    // fall through
   assign empty       = (count == '0);
   assign nearly_full = (count >= DEPTH - 1);

endmodule

/* hdl/queue_arbiter.sv */
/*
 * round-robin selection of one receive queue at packet boundaries,
 * per-queue pop lines and the selected head beat
 */
`include "ualink_settings.svh"

module queue_arbiter (
   input  logic                                              axi_aclk,
   input  logic                                              axi_resetn,
   input  ualink_pkg::axis_beat_t [`UALINK_NUM_QUEUES-1:0]   head,
   input  logic [`UALINK_NUM_QUEUES-1:0]                     empty,
   input  logic                                              load_ready,
   output logic [`UALINK_NUM_QUEUES-1:0]                     rd_en,
   output logic                                              pop,
   output ualink_pkg::axis_beat_t                            beat
);

   localparam int NQ = `UALINK_NUM_QUEUES;

   ualink_pkg::queue_sel_t cur_queue;    // last granted queue
   ualink_pkg::queue_sel_t next_queue;   // round-robin candidate
   ualink_pkg::queue_sel_t sel;
   logic                   in_packet;

   // first non-empty queue after cur_queue, wrapping
   // scan runs backwards so the nearest one wins
   always_comb begin
      int idx;
      next_queue = cur_queue;
      for (int k = NQ; k >= 1; k--) begin
         idx = int'(cur_queue) + k;
         if (idx >= NQ) idx = idx - NQ;
         if (!empty[idx]) next_queue = ualink_pkg::queue_sel_t'(idx);
      end
   end

   assign sel  = in_packet ? cur_queue : next_queue;   // grant held mid-packet
   assign pop  = !empty[sel] && load_ready;
   assign beat = head[sel];

   always_comb begin
      rd_en      = '0;
      rd_en[sel] = pop;
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         cur_queue <= ualink_pkg::queue_sel_t'(NQ - 1);   // queue 0 goes first
         in_packet <= 1'b0;
      end else if (pop) begin
         cur_queue <= sel;
         in_packet <= !beat.last;
      end
   end

endmodule

/* hdl/command_engine.sv */
/*
 * header decode of write/read commands, beat counting within a packet,
 * burst memory requests and the read-data substitute flag
 */
`include "ualink_settings.svh"

module command_engine (
   input  logic                   axi_aclk,
   input  logic                   axi_resetn,
   input  logic                   pop,
   input  ualink_pkg::axis_beat_t beat,
   output ualink_pkg::mem_req_t   mem_req,
   output logic                   substitute
);

   localparam int AW      = `UALINK_MEM_ADDR_WIDTH;
   localparam int CNT_MAX = `UALINK_BURST_BEATS + 1;   // saturates past the burst

   logic [$clog2(CNT_MAX+1)-1:0] beat_cnt;    // 0 is the header beat
   logic [AW-1:0]                base_addr;
   ualink_pkg::cmd_mode_t        mode;
   ualink_pkg::cmd_mode_t        hdr_mode;
   logic                         is_header;
   logic                         in_burst;

   assign is_header = (beat_cnt == '0);
   assign in_burst  = !is_header && (beat_cnt <= `UALINK_BURST_BEATS);

   // opcode lives in the top 16 bits of the header
   always_comb begin
      case (beat.data[63:48])
         `UALINK_OP_WRITE: hdr_mode = ualink_pkg::CMD_WRITE;
         `UALINK_OP_READ:  hdr_mode = ualink_pkg::CMD_READ;
         default:          hdr_mode = ualink_pkg::CMD_PASS;
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         beat_cnt <= '0;
         mode     <= ualink_pkg::CMD_PASS;
      end else if (pop) begin
         if (beat.last) beat_cnt <= '0;
         else if (beat_cnt != CNT_MAX) beat_cnt <= beat_cnt + 1'b1;
         if (is_header) mode <= hdr_mode;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (pop && is_header) base_addr <= beat.data[47:40];   // burst start address
   end

   // request in the cycle of pop; en follows pop so rdata holds under stall
   always_comb begin
      mem_req.en    = pop;
      mem_req.we    = pop && in_burst && (mode == ualink_pkg::CMD_WRITE);
      mem_req.addr  = base_addr + AW'(beat_cnt) - 1'b1;   // wraps modulo 256
      mem_req.wdata = beat.data;
   end

   assign substitute = in_burst && (mode == ualink_pkg::CMD_READ);

endmodule

/* hdl/burst_ram.sv */
/*
 * single-port burst memory, registered read, no contents reset
 */
`include "ualink_settings.svh"

module burst_ram (
   input  logic                          axi_aclk,
   input  ualink_pkg::mem_req_t          req,
   output logic [`UALINK_DATA_WIDTH-1:0] rdata
);

   localparam int DEPTH = 1 << `UALINK_MEM_ADDR_WIDTH;

   logic [`UALINK_DATA_WIDTH-1:0] mem [DEPTH];

   always_ff @(posedge axi_aclk) begin
      if (req.en) begin
         if (req.we) mem[req.addr] <= req.wdata;
         rdata <= mem[req.addr];   // old data on a write
      end
   end

endmodule

/* hdl/tx_stage.sv */
/*
 * one-entry output register slice on the transmit stream,
 * swaps in memory read data for flagged beats
 */
`include "ualink_settings.svh"

module tx_stage (
   input  logic                          axi_aclk,
   input  logic                          axi_resetn,
   input  logic                          pop,
   input  ualink_pkg::axis_beat_t        beat,
   input  logic                          substitute,
   input  logic [`UALINK_DATA_WIDTH-1:0] rdata,
   output logic                          load_ready,
   output ualink_pkg::axis_beat_t        m_axis,
   output logic                          m_axis_tvalid,
   input  logic                          m_axis_tready
);

   ualink_pkg::axis_beat_t beat_q;
   logic                   sub_q;
   logic                   valid_q;

   assign load_ready = !valid_q || m_axis_tready;   // empty or draining this cycle

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) valid_q <= 1'b0;
      else if (pop) valid_q <= 1'b1;
      else if (m_axis_tready) valid_q <= 1'b0;
   end

   always_ff @(posedge axi_aclk) begin
      if (pop) begin
         beat_q <= beat;
         sub_q  <= substitute;
      end
   end

   // rdata lands with the beat it replaces
   always_comb begin
      m_axis = beat_q;
      if (sub_q) m_axis.data = rdata;
   end

   assign m_axis_tvalid = valid_q;

endmodule

/* hdl/ualink_turbo.sv */
/*
 * UALink command bridge top: five receive queues, arbiter,
 * command engine, burst memory and transmit register slice
 */
`include "ualink_settings.svh"

module ualink_turbo (
   input  logic                                             axi_aclk,
   input  logic                                             axi_resetn,
   input  ualink_pkg::axis_beat_t [`UALINK_NUM_QUEUES-1:0]  s_axis,
   input  logic [`UALINK_NUM_QUEUES-1:0]                    s_axis_tvalid,
   output logic [`UALINK_NUM_QUEUES-1:0]                    s_axis_tready,
   output ualink_pkg::axis_beat_t                           m_axis,
   output logic                                             m_axis_tvalid,
   input  logic                                             m_axis_tready
);

   ualink_pkg::axis_beat_t [`UALINK_NUM_QUEUES-1:0] head;
   logic [`UALINK_NUM_QUEUES-1:0]                   empty;
   logic [`UALINK_NUM_QUEUES-1:0]                   nearly_full;
   logic [`UALINK_NUM_QUEUES-1:0]                   rd_en;
   logic                                            pop;
   ualink_pkg::axis_beat_t                          beat;
   ualink_pkg::mem_req_t                            mem_req;
   logic [`UALINK_DATA_WIDTH-1:0]                   rdata;
   logic                                            substitute;
   logic                                            load_ready;

   for (genvar i = 0; i < `UALINK_NUM_QUEUES; i++) begin : g_rx
      assign s_axis_tready[i] = !nearly_full[i];

      rx_queue #(.T(ualink_pkg::axis_beat_t), .DEPTH_BITS(`UALINK_QUEUE_DEPTH_BITS)) u_rx_queue (
         .axi_aclk, .axi_resetn,
         .din(s_axis[i]), .wr_en(s_axis_tvalid[i] && s_axis_tready[i]), .rd_en(rd_en[i]),
         .dout(head[i]), .empty(empty[i]), .nearly_full(nearly_full[i])
      );
   end

   queue_arbiter u_arbiter (
      .axi_aclk, .axi_resetn,
      .head, .empty, .load_ready,
      .rd_en, .pop, .beat
   );

   command_engine u_command_engine (
      .axi_aclk, .axi_resetn,
      .pop, .beat, .mem_req, .substitute
   );

   burst_ram u_burst_ram (.axi_aclk, .req(mem_req), .rdata);

   tx_stage u_tx_stage (
      .axi_aclk, .axi_resetn,
      .pop, .beat, .substitute, .rdata, .load_ready,
      .m_axis, .m_axis_tvalid, .m_axis_tready
   );

endmodule

/* testbench/ualink_turbo_chk.sv */
/*
 * bound assertions on the bridge ports: transmit hold under stall,
 * transmit valid in reset, no receive write past s_axis_tready
 */
`include "ualink_settings.svh"

module ualink_turbo_chk (
   input logic                          axi_aclk,
   input logic                          axi_resetn,
   input ualink_pkg::axis_beat_t        m_axis,
   input logic                          m_axis_tvalid,
   input logic                          m_axis_tready,
   input logic [`UALINK_NUM_QUEUES-1:0] s_axis_tready,
   input logic [`UALINK_NUM_QUEUES-1:0] rd_en
);

   int fail_count = 0;

   // offered beat must sit still until taken
   assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis))
   else begin
      $error("m_axis or m_axis_tvalid changed while m_axis_tready was low");
      fail_count++;
   end

   assert property (@(posedge axi_aclk) !axi_resetn |=> !m_axis_tvalid)
   else begin
      $error("m_axis_tvalid high during reset");
      fail_count++;
   end

   for (genvar i = 0; i < `UALINK_NUM_QUEUES; i++) begin : g_queue
      // a pop from a full queue reopens it unless a beat slipped in
      assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
         !s_axis_tready[i] && rd_en[i] |=> s_axis_tready[i])
      else begin
         $error("queue %0d took a beat while s_axis_tready was low", i);
         fail_count++;
      end
   end

endmodule

/* testbench/tb_ualink_turbo.sv */
/*
 * testbench for the command bridge: clock, reset, packet table,
 * stimulus loop, reference model and output checks
 */
`include "ualink_settings.svh"

module tb_ualink_turbo;

   localparam int         NQ         = `UALINK_NUM_QUEUES;
   localparam int         NROWS      = 12;
   localparam logic [1:0] STALL_NONE = 2'd0;
   localparam logic [1:0] STALL_HOLD = 2'd1;   // tready low while loading
   localparam logic [1:0] STALL_RAND = 2'd2;

   typedef struct packed {
      logic [2:0]  queue;
      logic [15:0] opcode;
      logic [7:0]  addr;
      logic [7:0]  len;
      logic [31:0] tag;
      logic [1:0]  stall;
   } row_t;

   localparam row_t ROWS [NROWS] = '{
      '{3'd2, 16'h0000,         8'h00, 8'd5,  32'h1000_0000, STALL_NONE},
      '{3'd0, `UALINK_OP_WRITE, 8'hfc, 8'd11, 32'h2000_0000, STALL_NONE},   // wraps past ff
      '{3'd1, `UALINK_OP_READ,  8'hfc, 8'd10, 32'h3000_0000, STALL_NONE},
      '{3'd3, `UALINK_OP_WRITE, 8'h40, 8'd9,  32'h4000_0000, STALL_NONE},
      '{3'd4, `UALINK_OP_READ,  8'h80, 8'd9,  32'h5000_0000, STALL_NONE},   // never written
      '{3'd0, 16'h0345,         8'h40, 8'd9,  32'h6000_0000, STALL_NONE},   // unknown opcode
      '{3'd1, `UALINK_OP_READ,  8'h40, 8'd9,  32'h7000_0000, STALL_NONE},
      '{3'd0, 16'h00a5,         8'h00, 8'd6,  32'h8000_0000, STALL_HOLD},
      '{3'd1, 16'h0011,         8'h00, 8'd6,  32'h9000_0000, STALL_HOLD},
      '{3'd3, 16'h0022,         8'h00, 8'd6,  32'ha000_0000, STALL_HOLD},
      '{3'd2, `UALINK_OP_READ,  8'hfc, 8'd10, 32'hb000_0000, STALL_RAND},
      '{3'd4, 16'h0033,         8'h00, 8'd20, 32'hc000_0000, STALL_HOLD}    // fills queue 4
   };

   logic                            axi_aclk;
   logic                            axi_resetn;
   ualink_pkg::axis_beat_t [NQ-1:0] s_axis;
   logic [NQ-1:0]                   s_axis_tvalid;
   logic [NQ-1:0]                   s_axis_tready;
   ualink_pkg::axis_beat_t          m_axis;
   logic                            m_axis_tvalid;
   logic                            m_axis_tready;

   logic [63:0]            model_mem [256];   // X until written, like the RAM
   ualink_pkg::axis_beat_t pkt [$];
   ualink_pkg::axis_beat_t expected [$];
   ualink_pkg::axis_beat_t exp_beat;
   integer                 seed = 32'hc8d5_c969;
   int                     errors = 0;
   int                     checked = 0;
   int                     cycles = 0;
   logic                   hold_sink = 1'b0;
   logic                   random_sink = 1'b0;

   ualink_turbo UUT (.axi_aclk, .axi_resetn, .s_axis, .s_axis_tvalid, .s_axis_tready,
                     .m_axis, .m_axis_tvalid, .m_axis_tready);

   bind ualink_turbo ualink_turbo_chk u_chk (.axi_aclk, .axi_resetn, .m_axis,
      .m_axis_tvalid, .m_axis_tready, .s_axis_tready, .rd_en);

   initial begin
      axi_aclk = 1'b0;
      forever #20 axi_aclk = ~axi_aclk;
   end

   // sink ready picked at the rising edge, driven at the falling edge
   initial begin
      logic next_ready;
      m_axis_tready = 1'b1;
      forever begin
         @(posedge axi_aclk);
         if (hold_sink) next_ready = 1'b0;
         else if (random_sink) next_ready = 1'($random(seed));
         else next_ready = 1'b1;
         @(negedge axi_aclk);
         m_axis_tready = next_ready;
      end
   end

   initial begin
      int limit;
      limit = 200;
      for (int r = 0; r < NROWS; r++) limit += 4 * ROWS[r].len;
      while (cycles < limit) begin
         @(posedge axi_aclk);
         cycles++;
      end
      errors++;
      $display("timeout after %0d cycles, %0d expected beats never came out",
               cycles, expected.size());
      $display("%0d beats checked, %0d errors", checked, errors + UUT.u_chk.fail_count);
      $display("CHECKS FAILED");
      $finish;
   end

   task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         errors++;
         $display("FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   always @(posedge axi_aclk) begin
      if (axi_resetn && m_axis_tvalid && m_axis_tready) begin
         if (expected.size() == 0) begin
            errors++;
            $display("extra beat on m_axis with nothing expected, data %h", m_axis.data);
         end else begin
            exp_beat = expected.pop_front();
            checked++;
            check_field("m_axis.data", m_axis.data, exp_beat.data);
            check_field("m_axis.strb", 64'(m_axis.strb), 64'(exp_beat.strb));
            check_field("m_axis.user", 64'(m_axis.user), 64'(exp_beat.user));
            check_field("m_axis.last", 64'(m_axis.last), 64'(exp_beat.last));
         end
      end
   end

   // writes store beats 1..8 from the header address on, reads replace them
   task automatic build_packet(input row_t row);
      ualink_pkg::axis_beat_t b;
      ualink_pkg::axis_beat_t e;
      ualink_pkg::cmd_mode_t  mode;
      logic [7:0]             a;
      logic [31:0]            lo;
      logic [31:0]            hi;
      mode = ualink_pkg::CMD_PASS;
      if (row.opcode == `UALINK_OP_WRITE) mode = ualink_pkg::CMD_WRITE;
      if (row.opcode == `UALINK_OP_READ) mode = ualink_pkg::CMD_READ;
      pkt.delete();
      for (int i = 0; i < row.len; i++) begin
         lo = $random(seed);
         hi = $random(seed);
         b.data = (i == 0) ? {row.opcode, row.addr, 8'h00, lo} : {hi, lo};
         b.strb = 8'($random(seed));
         b.user = row.tag + 32'(i);
         b.last = (i == row.len - 1);
         e = b;
         a = row.addr + 8'(i) - 8'd1;   // modulo 256
         if (i >= 1 && i <= `UALINK_BURST_BEATS) begin
            if (mode == ualink_pkg::CMD_WRITE) model_mem[a] = b.data;
            if (mode == ualink_pkg::CMD_READ) e.data = model_mem[a];
         end
         pkt.push_back(b);
         expected.push_back(e);
      end
   endtask

   task automatic send_packet(input row_t row);
      int   i;
      logic refused;
      i = 0;
      refused = 1'b0;
      while (i < row.len) begin
         @(negedge axi_aclk);
         s_axis[row.queue] = pkt[i];
         s_axis_tvalid[row.queue] = 1'b1;
         if (s_axis_tready[row.queue]) i++;
         else begin
            refused = 1'b1;
            hold_sink = 1'b0;   // queue full, let it drain
         end
      end
      @(negedge axi_aclk);
      s_axis_tvalid[row.queue] = 1'b0;
      if (row.stall == STALL_HOLD && row.len > (1 << `UALINK_QUEUE_DEPTH_BITS) && !refused) begin
         errors++;
         $display("s_axis_tready stayed high while queue %0d filled under stall", row.queue);
      end
   endtask

   task automatic wait_drain();
      while (expected.size() != 0) @(negedge axi_aclk);
   endtask

   initial begin
      axi_resetn    = 1'b0;
      s_axis        = '0;
      s_axis_tvalid = '0;
      repeat (16) @(negedge axi_aclk);
      axi_resetn = 1'b1;
      @(negedge axi_aclk);
      check_field("m_axis_tvalid", 64'(m_axis_tvalid), 64'd0);
      check_field("s_axis_tready", 64'(s_axis_tready), 64'((1 << NQ) - 1));
      for (int r = 0; r < NROWS; r++) begin
         // held rows pile up in their queues
         if (ROWS[r].stall != STALL_HOLD || r == 0 || ROWS[r-1].stall != STALL_HOLD) wait_drain();
         hold_sink   = (ROWS[r].stall == STALL_HOLD);
         random_sink = (ROWS[r].stall == STALL_RAND);
         build_packet(ROWS[r]);
         send_packet(ROWS[r]);
         if (r == NROWS - 1 || ROWS[r+1].stall != STALL_HOLD) hold_sink = 1'b0;
      end
      random_sink = 1'b0;
      wait_drain();
      repeat (8) @(negedge axi_aclk);   // window for stray beats
      errors += UUT.u_chk.fail_count;
      $display("%0d beats checked, %0d errors", checked, errors);
      if (errors == 0) $display("ALL CHECKS PASSED");
      else $display("CHECKS FAILED");
      $finish;
   end

endmodule

/* sim.f */
+incdir+.
hdl/ualink_pkg.sv
hdl/rx_queue.sv
hdl/queue_arbiter.sv
hdl/command_engine.sv
hdl/burst_ram.sv
hdl/tx_stage.sv
hdl/ualink_turbo.sv
testbench/ualink_turbo_chk.sv
testbench/tb_ualink_turbo.sv

/* Bender.yml */
package:
  name: ualink_turbo

sources:
  - include_dirs:
      - .
    files:
      - hdl/ualink_pkg.sv
      - hdl/rx_queue.sv
      - hdl/queue_arbiter.sv
      - hdl/command_engine.sv
      - hdl/burst_ram.sv
      - hdl/tx_stage.sv
      - hdl/ualink_turbo.sv
  - target: test
    include_dirs:
      - .
    files:
      - testbench/ualink_turbo_chk.sv
      - testbench/tb_ualink_turbo.sv
